// File: design/arb_defs.svh
// Global sizes and the register map of the arbitration subsystem.
// Include this header in any file that needs a width or an address offset.

`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// ----------------------------------------------------------
// Datapath sizing
// ----------------------------------------------------------
`define ARB_NUM_REQ 4
`define ARB_DATA_W 16
// Must be wide enough to index every requester
`define ARB_SRC_W 2

// ----------------------------------------------------------
// AXI4-Lite register port
// ----------------------------------------------------------
`define ARB_AXIL_ADDR_W 8
`define ARB_AXIL_DATA_W 32

// Control register holds enable in bit 0 and counter clear in bit 1
`define ARB_REG_CTRL 8'h00
// Grant counter i lives at this base plus 4 times i
`define ARB_REG_CNT_BASE 8'h10

`endif

// File: design/arb_pkg.sv
// Shared types of the arbitration subsystem.
// Holds the beat record, the AXI4-Lite channel bundles and the FSM enums.

`include "arb_defs.svh"

package arb_pkg;

  // One beat as it leaves the mux, tagged with the requester it came from
  typedef struct packed {
    logic [`ARB_SRC_W-1:0]  src;
    logic [`ARB_DATA_W-1:0] data;
  } arb_beat_t;

  // Standard AXI4-Lite response codes, only two are ever produced here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // Signals driven by the bus master
  typedef struct packed {
    logic [`ARB_AXIL_ADDR_W-1:0]   awaddr;
    logic                          awvalid;
    logic [`ARB_AXIL_DATA_W-1:0]   wdata;
    logic [`ARB_AXIL_DATA_W/8-1:0] wstrb;
    logic                          wvalid;
    logic                          bready;
    logic [`ARB_AXIL_ADDR_W-1:0]   araddr;
    logic                          arvalid;
    logic                          rready;
  } axil_req_t;

  // Signals driven by the register slave
  typedef struct packed {
    logic                        awready;
    logic                        wready;
    logic                        bvalid;
    axil_resp_e                  bresp;
    logic                        arready;
    logic                        rvalid;
    logic [`ARB_AXIL_DATA_W-1:0] rdata;
    axil_resp_e                  rresp;
  } axil_rsp_t;

  typedef enum logic {WR_IDLE, WR_RESP} axil_wr_state_e;
  typedef enum logic {RD_IDLE, RD_DATA} axil_rd_state_e;

endpackage

// File: design/arb_lru.sv
// Least-recently-used matrix arbiter.
// Grants at most one active request per cycle, combinationally. The winner
// drops to lowest priority at every edge where enable and a request are high.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_lru #(
  // Two or more requesters
  parameter int num_req = `ARB_NUM_REQ
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               enable,
  input  logic [num_req-1:0] request,
  output logic [num_req-1:0] grant
);

  // Only the upper triangle of the priority matrix is stored
  localparam int num_bits = num_req * (num_req - 1) / 2;

  // ----------------------------------------------------------
  // Priority matrix
  // ----------------------------------------------------------
  // prio[i][j] set means requester i was used less recently than j and so
  // beats it. Bit (i,j) with i < j sits in lru_q, packed row after row
  logic [num_bits-1:0]              lru_q;
  logic [num_bits-1:0]              lru_d;
  logic [num_req-1:0][num_req-1:0]  prio;
  logic [num_req-1:0]               can_grant;

  for (genvar i = 0; i < num_req; i++) begin : g_row
    for (genvar j = 0; j < num_req; j++) begin : g_col
      if (i < j) begin : g_upper
        // Offset of row i plus the position of column j inside that row
        localparam int idx = i * num_req - (i * (i + 1)) / 2 + (j - i - 1);
        assign prio[i][j] = lru_q[idx];
        // A granted row drops below everyone, a granted column goes below row i
        assign lru_d[idx] = grant[i] ? 1'b0 : (grant[j] ? 1'b1 : lru_q[idx]);
      end else if (i > j) begin : g_lower
        // Lower half mirrors the stored half
        assign prio[i][j] = ~prio[j][i];
      end else begin : g_diag
        // A requester is never compared with itself
        assign prio[i][j] = 1'b0;
      end
    end
  end

  // All ones after reset so the lowest index wins every tie at start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lru_q <= '1;
    end else if (enable && |request) begin
      lru_q <= lru_d;
    end
  end

  // ----------------------------------------------------------
  // Grant search
  // ----------------------------------------------------------
  // Requester i may win only when every other active requester is below it
  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      can_grant[i] = 1'b1;
      for (int j = 0; j < num_req; j++) begin
        if (i != j) begin
          can_grant[i] &= ~request[j] | prio[i][j];
        end
      end
    end
  end

  // Nothing is granted while the consumer cannot take a beat
  assign grant = enable ? (request & can_grant) : '0;

endmodule

// File: design/arb_flow_mux.sv
// Valid/ready front end of the arbitration subsystem.
// Picks one requester per cycle with the LRU arbiter, returns ready only to
// the winner and forwards its payload tagged with the source index.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_flow_mux (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      arb_enable,
  input  logic [`ARB_NUM_REQ-1:0]                   in_valid,
  input  logic [`ARB_NUM_REQ-1:0][`ARB_DATA_W-1:0]  in_beat_data,
  output logic [`ARB_NUM_REQ-1:0]                   in_ready,
  output logic                                      sel_valid,
  output arb_pkg::arb_beat_t                        sel_beat,
  input  logic                                      sel_ready,
  output logic [`ARB_NUM_REQ-1:0]                   grant
);

  logic                    lru_enable;
  logic [`ARB_NUM_REQ-1:0] lru_grant;
  logic [`ARB_SRC_W-1:0]   sel_src;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------
  // The arbiter only moves when the slice can take the beat, so every
  // grant it raises is also a completed transfer on that cycle
  assign lru_enable = sel_ready & arb_enable;

  arb_lru #(
    .num_req(`ARB_NUM_REQ)
  ) lru0 (
    .clk    (clk),
    .arst_n (arst_n),
    .enable (lru_enable),
    .request(in_valid),
    .grant  (lru_grant)
  );

  // ----------------------------------------------------------
  // Handshake steering
  // ----------------------------------------------------------
  // Ready goes back to the winner alone
  assign in_ready = lru_grant;

  // A valid output exists exactly when somebody was granted
  assign sel_valid = |lru_grant;

  // The register block counts these pulses
  assign grant = lru_grant;

  // ----------------------------------------------------------
  // Beat selection
  // ----------------------------------------------------------
  // One-hot to binary. The grant has at most one bit set, so the loop order
  // does not matter
  always_comb begin
    sel_src = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (lru_grant[i]) begin
        sel_src = `ARB_SRC_W'(i);
      end
    end
  end

  // Payload of the winner with its index attached.
  // When nothing is granted this shows requester 0, and sel_valid is low
  always_comb begin
    sel_beat.src  = sel_src;
    sel_beat.data = in_beat_data[sel_src];
  end

endmodule

// File: design/arb_out_slice.sv
// Two-entry skid buffer on the output of the mux.
// Registers every beat, keeps arrival order and offers a registered ready
// so back-pressure does not ripple combinationally into the arbiter.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_out_slice (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  arb_pkg::arb_beat_t in_beat,
  output logic               in_ready,
  output logic               out_valid,
  output arb_pkg::arb_beat_t out_beat,
  input  logic               out_ready
);

  logic               skid_valid;
  arb_pkg::arb_beat_t skid_beat;
  logic               in_fire;
  logic               main_load;

  assign in_fire = in_valid & in_ready;

  // Main register may take a new beat when empty or draining this cycle
  assign main_load = ~out_valid | out_ready;

  // Input is refused only while the skid entry holds a beat
  assign in_ready = ~skid_valid;

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        out_valid <= skid_valid | in_fire;
      end
      // A beat parks in the skid entry when the main one is stuck
      if (skid_valid) begin
        skid_valid <= ~out_ready;
      end else begin
        skid_valid <= in_fire & ~main_load;
      end
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------
  // The older skid beat always goes out before a fresh one
  always_ff @(posedge clk) begin
    if (main_load) begin
      out_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (in_fire && !main_load) begin
      skid_beat <= in_beat;
    end
  end

endmodule

// File: design/arb_csr_axil.sv
// AXI4-Lite register block of the arbitration subsystem.
// CTRL at offset 0 holds the global enable (bit 0) and a self-clearing
// counter clear (bit 1). Read-only 32-bit grant counters follow at 0x10.
// Unmapped offsets answer SLVERR and read as zero.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_csr_axil (
  input  logic                    clk,
  input  logic                    arst_n,
  input  arb_pkg::axil_req_t      axil_req,
  output arb_pkg::axil_rsp_t      axil_rsp,
  input  logic [`ARB_NUM_REQ-1:0] grant,
  output logic                    arb_enable
);

  arb_pkg::axil_wr_state_e                          wr_state;
  arb_pkg::axil_rd_state_e                          rd_state;
  arb_pkg::axil_resp_e                              bresp_q;
  arb_pkg::axil_resp_e                              rresp_q;
  logic [`ARB_AXIL_DATA_W-1:0]                      rdata_q;
  logic [`ARB_NUM_REQ-1:0][`ARB_AXIL_DATA_W-1:0]    cnt_q;
  logic                                             wr_fire;
  logic                                             rd_fire;
  logic                                             wr_ctrl_hit;
  logic                                             wr_cnt_hit;
  logic                                             rd_ctrl_hit;
  logic [`ARB_NUM_REQ-1:0]                          rd_cnt_sel;
  logic                                             cnt_clear;
  logic [`ARB_AXIL_DATA_W-1:0]                      rd_value;

  // One-hot match of an address against the counter slots
  function automatic logic [`ARB_NUM_REQ-1:0] cnt_decode(
    input logic [`ARB_AXIL_ADDR_W-1:0] addr
  );
    logic [`ARB_NUM_REQ-1:0] hit;
    hit = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      hit[i] = (addr == `ARB_AXIL_ADDR_W'(`ARB_REG_CNT_BASE + 4 * i));
    end
    return hit;
  endfunction

  // ----------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------
  // Address and data are taken together, and only from the idle state
  assign wr_fire = (wr_state == arb_pkg::WR_IDLE) & axil_req.awvalid & axil_req.wvalid;
  assign wr_ctrl_hit = (axil_req.awaddr == `ARB_REG_CTRL);
  assign wr_cnt_hit = |cnt_decode(axil_req.awaddr);

  // Clear takes effect at the same edge that accepts the write
  assign cnt_clear = wr_fire & wr_ctrl_hit & axil_req.wdata[1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state   <= arb_pkg::WR_IDLE;
      arb_enable <= 1'b0;
    end else begin
      case (wr_state)
        arb_pkg::WR_IDLE: begin
          if (wr_fire) begin
            wr_state <= arb_pkg::WR_RESP;
            // Byte strobes have no effect, every write updates the whole register
            if (wr_ctrl_hit) begin
              arb_enable <= axil_req.wdata[0];
            end
          end
        end
        arb_pkg::WR_RESP: begin
          if (axil_req.bready) begin
            wr_state <= arb_pkg::WR_IDLE;
          end
        end
        default: wr_state <= arb_pkg::WR_IDLE;
      endcase
    end
  end

  // Counter slots accept writes without effect and still answer OKAY
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= (wr_ctrl_hit | wr_cnt_hit) ? arb_pkg::OKAY : arb_pkg::SLVERR;
    end
  end

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  assign rd_fire = (rd_state == arb_pkg::RD_IDLE) & axil_req.arvalid;
  assign rd_ctrl_hit = (axil_req.araddr == `ARB_REG_CTRL);
  assign rd_cnt_sel = cnt_decode(axil_req.araddr);

  // CTRL bit 1 always reads back as zero
  always_comb begin
    rd_value = '0;
    if (rd_ctrl_hit) begin
      rd_value = {{(`ARB_AXIL_DATA_W - 1){1'b0}}, arb_enable};
    end
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (rd_cnt_sel[i]) begin
        rd_value = cnt_q[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= arb_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        arb_pkg::RD_IDLE: if (rd_fire) rd_state <= arb_pkg::RD_DATA;
        arb_pkg::RD_DATA: if (axil_req.rready) rd_state <= arb_pkg::RD_IDLE;
        default:          rd_state <= arb_pkg::RD_IDLE;
      endcase
    end
  end

  // Read data is sampled at acceptance and held until the master takes it
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_value;
      rresp_q <= (rd_ctrl_hit | (|rd_cnt_sel)) ? arb_pkg::OKAY : arb_pkg::SLVERR;
    end
  end

  // ----------------------------------------------------------
  // Grant counters
  // ----------------------------------------------------------
  // Free-running and wrapping. A clear wins over a grant in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (cnt_clear) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (grant[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Slave side of the bus
  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = (wr_state == arb_pkg::WR_RESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = (rd_state == arb_pkg::RD_IDLE);
    axil_rsp.rvalid  = (rd_state == arb_pkg::RD_DATA);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

// File: design/arb_subsys_top.sv
// Top level of the shared-resource arbitration subsystem.
// Requesters feed the flow mux, the chosen beat goes through the output
// skid buffer, and software controls the whole path over AXI4-Lite.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_subsys_top (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic [`ARB_NUM_REQ-1:0]                   in_valid,
  input  logic [`ARB_NUM_REQ-1:0][`ARB_DATA_W-1:0]  in_beat_data,
  output logic [`ARB_NUM_REQ-1:0]                   in_ready,
  output logic                                      out_valid,
  output arb_pkg::arb_beat_t                        out_beat,
  input  logic                                      out_ready,
  input  arb_pkg::axil_req_t                        axil_req,
  output arb_pkg::axil_rsp_t                        axil_rsp
);

  // Beat handed from the mux to the output slice
  logic                    sel_valid;
  logic                    sel_ready;
  arb_pkg::arb_beat_t      sel_beat;

  // Between the mux and the register block
  logic [`ARB_NUM_REQ-1:0] grant;
  logic                    arb_enable;

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  arb_flow_mux mux0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .arb_enable  (arb_enable),
    .in_valid    (in_valid),
    .in_beat_data(in_beat_data),
    .in_ready    (in_ready),
    .sel_valid   (sel_valid),
    .sel_beat    (sel_beat),
    .sel_ready   (sel_ready),
    .grant       (grant)
  );

  arb_out_slice slice0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (sel_valid),
    .in_beat  (sel_beat),
    .in_ready (sel_ready),
    .out_valid(out_valid),
    .out_beat (out_beat),
    .out_ready(out_ready)
  );

  // Enable and per-requester grant counts
  arb_csr_axil csr0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .grant     (grant),
    .arb_enable(arb_enable)
  );

endmodule

// File: dv/arb_properties.sv
// Concurrent checks on the arbiter grants and on an output handshake.
// Bound to the flow mux for the grant checks and to the subsystem top level
// for the output handshake checks.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_properties #(
  // Grant shape, enable gating and LRU fairness
  parameter bit grant_checks = 1'b1,
  // Output enable gating and stall stability
  parameter bit out_checks   = 1'b1
) (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    arb_enable,
  input logic [`ARB_NUM_REQ-1:0] in_valid,
  input logic [`ARB_NUM_REQ-1:0] grant,
  input logic                    out_valid,
  input logic                    out_ready,
  input arb_pkg::arb_beat_t      out_beat
);

  localparam int num_req = `ARB_NUM_REQ;

  // Read back by the testbench at the end of the run
  int fail_count = 0;

  if (grant_checks) begin : g_grant
    // Grants given to others while requester i was waiting
    logic [7:0] wait_cnt [num_req];

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        for (int i = 0; i < num_req; i++) begin
          wait_cnt[i] <= '0;
        end
      end else begin
        for (int i = 0; i < num_req; i++) begin
          if (!in_valid[i] || grant[i]) begin
            wait_cnt[i] <= '0;
          end else if (|grant) begin
            wait_cnt[i] <= wait_cnt[i] + 1'b1;
          end
        end
      end
    end

    // ----------------------------------------------------------
    // Grant shape and enable gating
    // ----------------------------------------------------------
    a_grant_legal: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(grant) && ((grant & ~in_valid) == '0))
      else begin
        fail_count++;
        $error("grant is not one-hot or goes to an idle requester");
      end

    a_no_grant_disabled: assert property (@(posedge clk) disable iff (!arst_n)
      !arb_enable |-> grant == '0)
      else begin
        fail_count++;
        $error("grant raised while arbitration is disabled");
      end

    // ----------------------------------------------------------
    // LRU fairness
    // ----------------------------------------------------------
    // Each other requester wins at most once before a waiting one is served
    for (genvar i = 0; i < num_req; i++) begin : g_fair
      a_fair: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid[i] && !grant[i] && (|grant) |-> wait_cnt[i] < num_req - 1)
        else begin
          fail_count++;
          $error("requester %0d passed over too many times", i);
        end
    end
  end

  if (out_checks) begin : g_out
    // A new output beat needs the enable, a held one may drain afterwards
    a_out_needs_enable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> arb_enable || $past(arb_enable) || $past(out_valid))
      else begin
        fail_count++;
        $error("output valid appeared without arbitration enabled");
      end

    // ----------------------------------------------------------
    // Output stall
    // ----------------------------------------------------------
    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else begin
        fail_count++;
        $error("output beat changed or dropped while stalled");
      end
  end

endmodule

// Arbiter side, where the grant is produced
bind arb_flow_mux arb_properties #(
  .grant_checks(1'b1),
  .out_checks  (1'b0)
) prop_mux (
  .clk       (clk),
  .arst_n    (arst_n),
  .arb_enable(arb_enable),
  .in_valid  (in_valid),
  .grant     (grant),
  .out_valid (sel_valid),
  .out_ready (sel_ready),
  .out_beat  (sel_beat)
);

// Output side, after the skid buffer
bind arb_subsys_top arb_properties #(
  .grant_checks(1'b0),
  .out_checks  (1'b1)
) prop_top (
  .clk       (clk),
  .arst_n    (arst_n),
  .arb_enable(arb_enable),
  .in_valid  (in_valid),
  .grant     (grant),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_beat  (out_beat)
);

// File: dv/arb_tb.sv
// Testbench for the arbitration subsystem.
// Four requesters send numbered beats, a scoreboard follows the output and
// the register block is checked over AXI4-Lite. Bound properties watch the
// arbiter and the output handshake at the same time.

`timescale 1ns/1ps
`include "arb_defs.svh"

module arb_tb;

  localparam int num_req     = `ARB_NUM_REQ;
  localparam int seq_w       = `ARB_DATA_W - `ARB_SRC_W;
  localparam int cycle_limit = 8000;

  logic                                     clk;
  logic                                     arst_n;
  logic [num_req-1:0]                       in_valid;
  logic [num_req-1:0][`ARB_DATA_W-1:0]      in_beat_data;
  logic [num_req-1:0]                       in_ready;
  logic                                     out_valid;
  arb_pkg::arb_beat_t                       out_beat;
  logic                                     out_ready;
  arb_pkg::axil_req_t                       axil_req;
  arb_pkg::axil_rsp_t                       axil_rsp;

  integer              seed = 32'hb39d_fccd;
  int                  sb_errors = 0;
  int                  cycle_cnt = 0;
  // Requester behavior: 0 holds off new beats, 1 always valid, 2 random
  int                  mode = 0;
  int                  sent_cnt [num_req];
  int                  recv_cnt [num_req];
  logic [num_req-1:0]  fire_q;

  arb_subsys_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_beat_data(in_beat_data),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_beat    (out_beat),
    .out_ready   (out_ready),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit, roughly twice the length of all phases together
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not complete within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      sb_errors++;
      $display("mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // ----------------------------------------------------------
  // Requesters and scoreboard
  // ----------------------------------------------------------
  // Handshakes are sampled at the falling edge where every signal is settled
  always begin
    @(negedge clk);
    fire_q = in_valid & in_ready;
    for (int i = 0; i < num_req; i++) begin
      if (fire_q[i]) begin
        sent_cnt[i]++;
      end
    end
    if (out_valid && out_ready) begin
      // Top bits of the payload name the requester, the rest is its sequence
      check_equal("out_beat.src", out_beat.data[`ARB_DATA_W-1 -: `ARB_SRC_W], out_beat.src);
      check_equal($sformatf("out_beat.data seq from src %0d", out_beat.src),
                  seq_w'(recv_cnt[out_beat.src]), out_beat.data[seq_w-1:0]);
      recv_cnt[out_beat.src]++;
    end
    @(posedge clk);
    #1;
    // A requester only picks a new beat once the previous one has left
    for (int i = 0; i < num_req; i++) begin
      if (fire_q[i] || !in_valid[i]) begin
        case (mode)
          1:       in_valid[i] = 1'b1;
          2:       in_valid[i] = $random(seed) & 1;
          default: in_valid[i] = 1'b0;
        endcase
        in_beat_data[i] = {`ARB_SRC_W'(i), seq_w'(sent_cnt[i])};
      end
    end
    out_ready = (mode == 2) ? ($random(seed) & 1) : 1'b1;
  end

  // ----------------------------------------------------------
  // AXI4-Lite master
  // ----------------------------------------------------------
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output arb_pkg::axil_resp_e resp);
    @(posedge clk);
    #1;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.awready);
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    do @(negedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output arb_pkg::axil_resp_e resp);
    @(posedge clk);
    #1;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  // Mode changes land on a falling edge, away from the requester updates
  task automatic run_phase(input int new_mode, input int cycles);
    @(negedge clk);
    mode = new_mode;
    repeat (cycles) @(negedge clk);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    arb_pkg::axil_resp_e resp;
    logic [31:0]         rdata;
    int                  prop_errors;

    arst_n       = 1'b0;
    in_valid     = '0;
    in_beat_data = '0;
    out_ready    = 1'b1;
    axil_req     = '0;
    fire_q       = '0;
    for (int i = 0; i < num_req; i++) begin
      sent_cnt[i] = 0;
      recv_cnt[i] = 0;
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Requests pending while the arbiter is still disabled
    run_phase(1, 20);
    axil_write(`ARB_REG_CTRL, 32'h1, resp);
    check_equal("bresp CTRL enable", arb_pkg::OKAY, resp);

    // Saturated fairness, then random valids with output stalls
    run_phase(1, 1000);
    run_phase(2, 2500);

    // Let every pending beat reach the output
    mode = 0;
    do @(negedge clk); while (in_valid != '0 || out_valid);
    repeat (4) @(negedge clk);

    // Disabled again, new requests must stay ungranted
    axil_write(`ARB_REG_CTRL, 32'h0, resp);
    run_phase(1, 20);
    mode = 0;

    for (int i = 0; i < num_req; i++) begin
      check_equal($sformatf("beats delivered from src %0d", i), sent_cnt[i], recv_cnt[i]);
      axil_read(`ARB_REG_CNT_BASE + 4 * i, rdata, resp);
      check_equal($sformatf("rresp cnt[%0d]", i), arb_pkg::OKAY, resp);
      check_equal($sformatf("rdata cnt[%0d]", i), recv_cnt[i], rdata);
    end

    // Clear bit with enable left off
    axil_write(`ARB_REG_CTRL, 32'h2, resp);
    check_equal("bresp CTRL clear", arb_pkg::OKAY, resp);
    for (int i = 0; i < num_req; i++) begin
      axil_read(`ARB_REG_CNT_BASE + 4 * i, rdata, resp);
      check_equal($sformatf("rdata cnt[%0d] after clear", i), 32'h0, rdata);
    end

    // Mapped and unmapped offsets
    axil_read(`ARB_REG_CTRL, rdata, resp);
    check_equal("rresp CTRL", arb_pkg::OKAY, resp);
    check_equal("rdata CTRL", 32'h0, rdata);
    axil_read(8'h08, rdata, resp);
    check_equal("rresp 0x08", arb_pkg::SLVERR, resp);
    check_equal("rdata 0x08", 32'h0, rdata);
    axil_read(8'h20, rdata, resp);
    check_equal("rresp 0x20", arb_pkg::SLVERR, resp);
    check_equal("rdata 0x20", 32'h0, rdata);
    axil_write(8'h0c, 32'h5a5a_0001, resp);
    check_equal("bresp 0x0c", arb_pkg::SLVERR, resp);
    axil_write(`ARB_REG_CNT_BASE, 32'h1234, resp);
    check_equal("bresp cnt[0]", arb_pkg::OKAY, resp);

    repeat (4) @(negedge clk);
    prop_errors = dut0.prop_top.fail_count + dut0.mux0.prop_mux.fail_count;
    $display("summary: scoreboard errors %0d, assertion errors %0d", sb_errors, prop_errors);
    if (sb_errors == 0 && prop_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/arb_pkg.sv
design/arb_lru.sv
design/arb_flow_mux.sv
design/arb_out_slice.sv
design/arb_csr_axil.sv
design/arb_subsys_top.sv
dv/arb_properties.sv
dv/arb_tb.sv
